/* hw/aes_pkg.sv */
`default_nettype none

package aes_pkg;

  // ##########################################################################
  // Register map with the word index taken from wb_adr_i[5:2]
  // ##########################################################################
  localparam logic [3:0] REG_CTRL  = 4'd0;
  localparam logic [3:0] REG_PT0   = 4'd1;   // Least significant plaintext word
  localparam logic [3:0] REG_PT1   = 4'd2;
  localparam logic [3:0] REG_PT2   = 4'd3;
  localparam logic [3:0] REG_PT3   = 4'd4;
  localparam logic [3:0] REG_KEY0  = 4'd5;   // Least significant key word
  localparam logic [3:0] REG_KEY1  = 4'd6;
  localparam logic [3:0] REG_KEY2  = 4'd7;
  localparam logic [3:0] REG_KEY3  = 4'd8;
  localparam logic [3:0] REG_VALID = 4'd9;
  localparam logic [3:0] REG_CT0   = 4'd10;  // Bits 127 to 96 of the ciphertext
  localparam logic [3:0] REG_CT1   = 4'd11;
  localparam logic [3:0] REG_CT2   = 4'd12;
  localparam logic [3:0] REG_CT3   = 4'd13;

  localparam int BLOCK_W = 128;
  localparam int WORD_W  = 32;

  localparam logic [3:0] NUM_ROUNDS = 4'd10;

  // ##########################################################################
  // Forward S-box
  // ##########################################################################
  localparam logic [7:0] SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  function automatic logic [7:0] aes_sbox(input logic [7:0] b);
    return SBOX[b];
  endfunction

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] aes_xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

`default_nettype wire

/* hw/aes_key_expand.sv */
`default_nettype none

module aes_key_expand import aes_pkg::*; (
  input  wire  [BLOCK_W-1:0] round_key_i,
  input  wire  [7:0]         rcon_i,
  output logic [BLOCK_W-1:0] next_key_o,
  output logic [7:0]         next_rcon_o
);

  logic [31:0] w0;
  logic [31:0] w1;
  logic [31:0] w2;
  logic [31:0] w3;
  logic [31:0] rot;
  logic [31:0] temp;
  logic [31:0] n0;
  logic [31:0] n1;
  logic [31:0] n2;
  logic [31:0] n3;

  assign w0 = round_key_i[127:96];
  assign w1 = round_key_i[95:64];
  assign w2 = round_key_i[63:32];
  assign w3 = round_key_i[31:0];

  assign rot = {w3[23:0], w3[31:24]};  // RotWord

  // SubWord with the round constant folded into the top byte
  assign temp = {aes_sbox(rot[31:24]) ^ rcon_i,
                 aes_sbox(rot[23:16]),
                 aes_sbox(rot[15:8]),
                 aes_sbox(rot[7:0])};

  assign n0 = w0 ^ temp;
  assign n1 = w1 ^ n0;
  assign n2 = w2 ^ n1;
  assign n3 = w3 ^ n2;

  assign next_key_o  = {n0, n1, n2, n3};
  assign next_rcon_o = aes_xtime(rcon_i);

endmodule

`default_nettype wire

/* hw/aes_round.sv */
`default_nettype none

module aes_round import aes_pkg::*; (
  input  wire  [BLOCK_W-1:0] state_i,
  input  wire  [BLOCK_W-1:0] round_key_i,
  input  wire                last_i,
  output logic [BLOCK_W-1:0] state_o
);

  // Byte i sits at bits 127-8i down, row i%4 and column i/4
  logic [7:0] sb [16];
  logic [7:0] sr [16];
  logic [7:0] mc [16];

  always_comb begin
    for (int i = 0; i < 16; i++) begin
      sb[i] = aes_sbox(state_i[127-8*i -: 8]);
    end

    // Row r rotates left by r columns
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        sr[4*c+r] = sb[4*((c+r)%4)+r];
      end
    end

    for (int c = 0; c < 4; c++) begin
      mc[4*c]   = aes_xtime(sr[4*c]) ^ aes_xtime(sr[4*c+1]) ^ sr[4*c+1]
                  ^ sr[4*c+2] ^ sr[4*c+3];
      mc[4*c+1] = sr[4*c] ^ aes_xtime(sr[4*c+1]) ^ aes_xtime(sr[4*c+2])
                  ^ sr[4*c+2] ^ sr[4*c+3];
      mc[4*c+2] = sr[4*c] ^ sr[4*c+1] ^ aes_xtime(sr[4*c+2])
                  ^ aes_xtime(sr[4*c+3]) ^ sr[4*c+3];
      mc[4*c+3] = aes_xtime(sr[4*c]) ^ sr[4*c] ^ sr[4*c+1] ^ sr[4*c+2]
                  ^ aes_xtime(sr[4*c+3]);
    end

    // Final round has no MixColumns
    for (int i = 0; i < 16; i++) begin
      state_o[127-8*i -: 8] = (last_i ? sr[i] : mc[i]) ^ round_key_i[127-8*i -: 8];
    end
  end

endmodule

`default_nettype wire

/* hw/aes_core.sv */
`default_nettype none

module aes_core import aes_pkg::*; (
  input  wire                wb_clk_i,
  input  wire                wb_rst_i,
  input  wire                start_i,
  input  wire  [BLOCK_W-1:0] plaintext_i,
  input  wire  [BLOCK_W-1:0] key_i,
  output logic               busy_o,
  output logic               done_o,
  output logic [BLOCK_W-1:0] ct_o
);

  logic [BLOCK_W-1:0] state_q;
  logic [BLOCK_W-1:0] rkey_q;
  logic [7:0]         rcon_q;
  logic [3:0]         round_q;   // Round computed in the current cycle
  logic [BLOCK_W-1:0] round_out;
  logic [BLOCK_W-1:0] next_key;
  logic [7:0]         next_rcon;

  aes_key_expand u_key_expand (
    .round_key_i (rkey_q),
    .rcon_i      (rcon_q),
    .next_key_o  (next_key),
    .next_rcon_o (next_rcon)
  );

  // The round uses the key expanded in the same cycle
  aes_round u_round (
    .state_i     (state_q),
    .round_key_i (next_key),
    .last_i      (round_q == NUM_ROUNDS),
    .state_o     (round_out)
  );

  // ##########################################################################
  // Round sequencing with busy held high through the done cycle
  // ##########################################################################
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      busy_o  <= 1'b0;
      done_o  <= 1'b0;
      round_q <= '0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !busy_o) begin
        busy_o  <= 1'b1;
        round_q <= 4'd1;
      end else if (busy_o) begin
        if (done_o) begin
          busy_o <= 1'b0;
        end else begin
          round_q <= round_q + 4'd1;
          done_o  <= (round_q == NUM_ROUNDS);
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (start_i && !busy_o) begin
      state_q <= plaintext_i ^ key_i;  // Initial AddRoundKey
      rkey_q  <= key_i;
      rcon_q  <= 8'h01;
    end else if (busy_o && !done_o) begin
      state_q <= round_out;
      rkey_q  <= next_key;
      rcon_q  <= next_rcon;
    end
  end

  assign ct_o = state_q;

endmodule

`default_nettype wire

/* hw/aes_wb_regs.sv */
`default_nettype none

module aes_wb_regs import aes_pkg::*; (
  input  wire                wb_clk_i,
  input  wire                wb_rst_i,
  input  wire                wb_cyc_i,
  input  wire                wb_stb_i,
  input  wire                wb_we_i,
  input  wire [31:0]         wb_adr_i,
  input  wire [WORD_W-1:0]   wb_dat_i,
  output logic               wb_ack_o,
  output logic [BLOCK_W-1:0] plaintext_o,
  output logic [BLOCK_W-1:0] key_o,
  output logic               start_o,
  output logic               rd_en_o,
  output logic [3:0]         rd_idx_o
);

  logic [WORD_W-1:0] pt_q  [4];
  logic [WORD_W-1:0] key_q [4];
  logic              access;
  logic [3:0]        idx;

  // Gating with ack keeps a held strobe from counting twice
  assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign idx    = wb_adr_i[5:2];

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
      start_o  <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        pt_q[i]  <= '0;
        key_q[i] <= '0;
      end
    end else begin
      wb_ack_o <= access;
      start_o  <= access & wb_we_i & (idx == REG_CTRL) & wb_dat_i[0];
      if (access && wb_we_i) begin
        case (idx)
          REG_PT0:  pt_q[0]  <= wb_dat_i;
          REG_PT1:  pt_q[1]  <= wb_dat_i;
          REG_PT2:  pt_q[2]  <= wb_dat_i;
          REG_PT3:  pt_q[3]  <= wb_dat_i;
          REG_KEY0: key_q[0] <= wb_dat_i;
          REG_KEY1: key_q[1] <= wb_dat_i;
          REG_KEY2: key_q[2] <= wb_dat_i;
          REG_KEY3: key_q[3] <= wb_dat_i;
          default: ;  // Unmapped and read-only words
        endcase
      end
    end
  end

  // Highest numbered word ends up in the top bits
  assign plaintext_o = {pt_q[3], pt_q[2], pt_q[1], pt_q[0]};
  assign key_o       = {key_q[3], key_q[2], key_q[1], key_q[0]};

  assign rd_en_o  = access & ~wb_we_i;
  assign rd_idx_o = idx;

endmodule

`default_nettype wire

/* hw/aes_result_buf.sv */
`default_nettype none

module aes_result_buf import aes_pkg::*; (
  input  wire                wb_clk_i,
  input  wire                wb_rst_i,
  input  wire                done_i,
  input  wire                start_i,
  input  wire  [BLOCK_W-1:0] ct_i,
  input  wire                rd_en_i,
  input  wire  [3:0]         rd_idx_i,
  input  wire                busy_i,
  input  wire  [BLOCK_W-1:0] plaintext_i,
  input  wire  [BLOCK_W-1:0] key_i,
  output logic [WORD_W-1:0]  wb_dat_o
);

  logic [BLOCK_W-1:0] ct_q;
  logic               valid_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ct_q    <= '0;
      valid_q <= 1'b0;
    end else if (start_i && !busy_i) begin
      valid_q <= 1'b0;  // Only a start the core accepts clears the result
    end else if (done_i) begin
      ct_q    <= ct_i;
      valid_q <= 1'b1;
    end
  end

  // Read data is registered so it lines up with the ack
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_dat_o <= '0;
    end else if (rd_en_i) begin
      case (rd_idx_i)
        REG_CTRL:  wb_dat_o <= {31'b0, busy_i};
        REG_PT0:   wb_dat_o <= plaintext_i[31:0];
        REG_PT1:   wb_dat_o <= plaintext_i[63:32];
        REG_PT2:   wb_dat_o <= plaintext_i[95:64];
        REG_PT3:   wb_dat_o <= plaintext_i[127:96];
        REG_KEY0:  wb_dat_o <= key_i[31:0];
        REG_KEY1:  wb_dat_o <= key_i[63:32];
        REG_KEY2:  wb_dat_o <= key_i[95:64];
        REG_KEY3:  wb_dat_o <= key_i[127:96];
        REG_VALID: wb_dat_o <= {31'b0, valid_q};
        REG_CT0:   wb_dat_o <= ct_q[127:96];
        REG_CT1:   wb_dat_o <= ct_q[95:64];
        REG_CT2:   wb_dat_o <= ct_q[63:32];
        REG_CT3:   wb_dat_o <= ct_q[31:0];
        default:   wb_dat_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/aes_top.sv */
`default_nettype none

module aes_top import aes_pkg::*; (
  input  wire               wb_clk_i,
  input  wire               wb_rst_i,
  input  wire  [31:0]       wb_adr_i,
  input  wire  [1:0]        wb_bte_i,   // Bursts are not supported
  input  wire  [2:0]        wb_cti_i,
  input  wire               wb_cyc_i,
  input  wire  [WORD_W-1:0] wb_dat_i,
  input  wire  [3:0]        wb_sel_i,   // Registers are whole words
  input  wire               wb_stb_i,
  input  wire               wb_we_i,
  output logic              wb_ack_o,
  output logic              wb_err_o,
  output logic              wb_rty_o,
  output logic [WORD_W-1:0] wb_dat_o
);

  logic [BLOCK_W-1:0] plaintext;
  logic [BLOCK_W-1:0] key;
  logic [BLOCK_W-1:0] ct;
  logic               start;
  logic               busy;
  logic               done;
  logic               rd_en;
  logic [3:0]         rd_idx;

  assign wb_err_o = 1'b0;
  assign wb_rty_o = 1'b0;

  aes_wb_regs u_regs (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_o    (wb_ack_o),
    .plaintext_o (plaintext),
    .key_o       (key),
    .start_o     (start),
    .rd_en_o     (rd_en),
    .rd_idx_o    (rd_idx)
  );

  aes_core u_core (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .start_i     (start),
    .plaintext_i (plaintext),
    .key_i       (key),
    .busy_o      (busy),
    .done_o      (done),
    .ct_o        (ct)
  );

  aes_result_buf u_result (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .done_i      (done),
    .start_i     (start),
    .ct_i        (ct),
    .rd_en_i     (rd_en),
    .rd_idx_i    (rd_idx),
    .busy_i      (busy),
    .plaintext_i (plaintext),
    .key_i       (key),
    .wb_dat_o    (wb_dat_o)
  );

endmodule

`default_nettype wire

/* tests/aes_tb.sv */
`default_nettype none

module aes_tb import aes_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_BLOCKS     = 32;
  localparam int VALID_LATENCY  = 13;  // Bus cycles from the start write to valid
  localparam int ACK_LIMIT      = 4;
  localparam int TIMEOUT_CYCLES = 40 * 40 + 500;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [31:0] wb_adr_i;
  logic [1:0]  wb_bte_i;
  logic [2:0]  wb_cti_i;
  logic        wb_cyc_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic        wb_ack_o;
  logic        wb_err_o;
  logic        wb_rty_o;
  logic [31:0] wb_dat_o;

  int    cycle_cnt = 0;
  int    ack_cycle;     // Cycle of the edge that took the last access
  int    errors    = 0;
  int    checks    = 0;
  int    num_tests = 0;
  int    test_err0;
  string test_name;

  logic [7:0] sbox_tbl [256];

  aes_top u_dut (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_bte_i (wb_bte_i),
    .wb_cti_i (wb_cti_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .wb_rty_o (wb_rty_o),
    .wb_dat_o (wb_dat_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #4 wb_clk_i = ~wb_clk_i;
  end

  always @(posedge wb_clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  // ##########################################################################
  // Reference AES-128 model
  // ##########################################################################
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p = p ^ x;
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // Multiplicative inverse as b^254, then the affine transform
  function automatic logic [7:0] sbox_entry(input logic [7:0] b);
    logic [7:0] inv;
    inv = 8'h01;
    for (int i = 0; i < 254; i++) inv = gf_mul(inv, b);
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
           ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

  function automatic logic [127:0] aes128_encrypt(input logic [127:0] pt,
                                                  input logic [127:0] key);
    logic [31:0]  w [44];
    logic [7:0]   s [16];
    logic [7:0]   t [16];
    logic [31:0]  tmp;
    logic [7:0]   rc;
    logic [127:0] ct;
    rc = 8'h01;
    for (int i = 0; i < 4; i++) w[i] = key[127-32*i -: 32];
    for (int i = 4; i < 44; i++) begin
      tmp = w[i-1];
      if (i % 4 == 0) begin
        tmp = {sbox_tbl[tmp[23:16]] ^ rc, sbox_tbl[tmp[15:8]],
               sbox_tbl[tmp[7:0]], sbox_tbl[tmp[31:24]]};
        rc = gf_mul(rc, 8'h02);
      end
      w[i] = w[i-4] ^ tmp;
    end
    for (int i = 0; i < 16; i++) s[i] = pt[127-8*i -: 8] ^ w[i/4][31-8*(i%4) -: 8];
    for (int rnd = 1; rnd <= 10; rnd++) begin
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) t[4*c+r] = sbox_tbl[s[4*((c+r)%4)+r]];
      end
      for (int c = 0; c < 4; c++) begin
        if (rnd < 10) begin
          s[4*c]   = gf_mul(t[4*c], 8'h02) ^ gf_mul(t[4*c+1], 8'h03) ^ t[4*c+2] ^ t[4*c+3];
          s[4*c+1] = t[4*c] ^ gf_mul(t[4*c+1], 8'h02) ^ gf_mul(t[4*c+2], 8'h03) ^ t[4*c+3];
          s[4*c+2] = t[4*c] ^ t[4*c+1] ^ gf_mul(t[4*c+2], 8'h02) ^ gf_mul(t[4*c+3], 8'h03);
          s[4*c+3] = gf_mul(t[4*c], 8'h03) ^ t[4*c+1] ^ t[4*c+2] ^ gf_mul(t[4*c+3], 8'h02);
        end else begin
          for (int r = 0; r < 4; r++) s[4*c+r] = t[4*c+r];
        end
        for (int r = 0; r < 4; r++) s[4*c+r] = s[4*c+r] ^ w[4*rnd+c][31-8*r -: 8];
      end
    end
    for (int i = 0; i < 16; i++) ct[127-8*i -: 8] = s[i];
    return ct;
  endfunction

  function automatic logic [127:0] rand128();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // ##########################################################################
  // Bus access and checking
  // ##########################################################################
  task automatic bus_access(input logic we, input logic [3:0] idx, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int waited;
    waited   = 0;
    rdata    = '0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {26'b0, idx, 2'b00};
    wb_dat_i = wdata;
    do begin
      @(posedge wb_clk_i);
      #1;
      waited++;
    end while (!wb_ack_o && waited < ACK_LIMIT);
    if (wb_ack_o) begin
      rdata     = wb_dat_o;
      ack_cycle = cycle_cnt;
    end else begin
      $display("No acknowledge for the access to word %0d at time %0t", idx, $time);
      errors++;
    end
    if (wb_err_o || wb_rty_o) begin
      $display("Error or retry raised on the access to word %0d at time %0t", idx, $time);
      errors++;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic reg_write(input logic [3:0] idx, input logic [31:0] data);
    logic [31:0] unused_rd;
    bus_access(1'b1, idx, data, unused_rd);
  endtask

  task automatic reg_read(input logic [3:0] idx, output logic [31:0] data);
    bus_access(1'b0, idx, 32'h0, data);
  endtask

  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    num_tests++;
    $display("Test %-18s %s", test_name, (errors == test_err0) ? "pass" : "fail");
  endtask

  // Word 1 carries the least significant plaintext bits
  task automatic load_block(input logic [127:0] pt, input logic [127:0] key);
    for (int k = 0; k < 4; k++) reg_write(REG_PT0 + 4'(k), pt[32*k +: 32]);
    for (int k = 0; k < 4; k++) reg_write(REG_KEY0 + 4'(k), key[32*k +: 32]);
  endtask

  // Valid must read 0 before the latency has passed and 1 from then on
  task automatic wait_valid(input int start_cyc);
    logic [31:0] rd;
    int          elapsed;
    do begin
      reg_read(REG_VALID, rd);
      elapsed = ack_cycle - start_cyc;
      compare_word("valid flag", rd, {31'b0, elapsed >= VALID_LATENCY});
    end while (elapsed < VALID_LATENCY);
  endtask

  task automatic check_ct(input logic [127:0] exp);
    logic [31:0] rd;
    for (int k = 0; k < 4; k++) begin
      reg_read(REG_CT0 + 4'(k), rd);
      compare_word("ciphertext word", rd, exp[127-32*k -: 32]);
    end
  endtask

  task automatic run_block(input logic [127:0] pt, input logic [127:0] key,
                           input logic [127:0] exp);
    logic [31:0] rd;
    int          start_cyc;
    load_block(pt, key);
    reg_write(REG_CTRL, 32'h1);
    start_cyc = ack_cycle;
    reg_read(REG_CTRL, rd);
    compare_word("busy while running", rd, 32'h1);
    wait_valid(start_cyc);
    check_ct(exp);
  endtask

  // ##########################################################################
  // Tests
  // ##########################################################################
  initial begin
    logic [31:0]  rd;
    logic [31:0]  words [8];
    logic [127:0] pt_a;
    logic [127:0] key_a;
    logic [127:0] pt_b;
    logic [127:0] key_b;
    int           start_cyc;

    wb_rst_i = 1'b1;
    wb_adr_i = '0;
    wb_bte_i = '0;
    wb_cti_i = '0;
    wb_cyc_i = 1'b0;
    wb_dat_i = '0;
    wb_sel_i = 4'hf;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    void'($urandom(35213));
    for (int i = 0; i < 256; i++) sbox_tbl[i] = sbox_entry(i[7:0]);

    repeat (2) @(posedge wb_clk_i);
    #1 wb_rst_i = 1'b0;

    begin_test("reset_state");
    for (int k = 0; k < 16; k++) begin
      reg_read(4'(k), rd);
      compare_word("word after reset", rd, 32'h0);
    end
    end_test();

    begin_test("register_readback");
    for (int k = 0; k < 8; k++) begin
      words[k] = $urandom;
      reg_write(REG_PT0 + 4'(k), words[k]);
    end
    reg_write(4'd14, $urandom);
    reg_write(4'd15, $urandom);
    for (int k = 0; k < 8; k++) begin
      reg_read(REG_PT0 + 4'(k), rd);
      compare_word("stored word", rd, words[k]);
    end
    reg_read(4'd14, rd);
    compare_word("unmapped word 14", rd, 32'h0);
    reg_read(4'd15, rd);
    compare_word("unmapped word 15", rd, 32'h0);
    end_test();

    begin_test("known_answer");  // FIPS-197 appendix C.1
    run_block(128'h00112233445566778899aabbccddeeff, 128'h000102030405060708090a0b0c0d0e0f,
              128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    end_test();

    begin_test("random_blocks");
    for (int n = 0; n < NUM_BLOCKS; n++) begin
      pt_a  = rand128();
      key_a = rand128();
      run_block(pt_a, key_a, aes128_encrypt(pt_a, key_a));
    end
    end_test();

    begin_test("start_while_busy");
    pt_a  = rand128();
    key_a = rand128();
    pt_b  = {pt_a[127:32], $urandom};
    key_b = {$urandom, key_a[95:0]};
    load_block(pt_a, key_a);
    reg_write(REG_CTRL, 32'h1);
    start_cyc = ack_cycle;
    reg_write(REG_PT0, pt_b[31:0]);
    reg_write(REG_KEY3, key_b[127:96]);
    reg_read(REG_CTRL, rd);
    compare_word("busy before second start", rd, 32'h1);
    reg_write(REG_CTRL, 32'h1);  // Arrives while the core is busy
    wait_valid(start_cyc);
    check_ct(aes128_encrypt(pt_a, key_a));
    reg_write(REG_CTRL, 32'h1);
    start_cyc = ack_cycle;
    reg_read(REG_VALID, rd);
    compare_word("valid after new start", rd, 32'h0);
    wait_valid(start_cyc);
    check_ct(aes128_encrypt(pt_b, key_b));
    end_test();

    $display("Tests: %0d, checks: %0d, errors: %0d", num_tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hw/aes_pkg.sv
hw/aes_key_expand.sv
hw/aes_round.sv
hw/aes_core.sv
hw/aes_wb_regs.sv
hw/aes_result_buf.sv
hw/aes_top.sv
tests/aes_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f build.f --top-module aes_tb --Mdir obj_dir -o aes_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/aes_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation passed"
exit 0
